// File: flist.f
+incdir+hw
hw/conv_pkg.sv
hw/tile_ctrl_if.sv
hw/int8_to_bf16.sv
hw/line_assembler.sv
hw/tile_buffer.sv
hw/tile_word_counter.sv
hw/tile_ctrl_fsm.sv
hw/tile_convert_top.sv
testbench/tb_tile_convert.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the tile conversion testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f flist.f --top-module tb_tile_convert -Mdir "$OBJ"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_tile_convert" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
exit 0

// File: testbench/tb_tile_convert.sv
`timescale 1ns/100ps
`include "conv_cfg.svh"

module tb_tile_convert;

    localparam int LOAD_N = `LOAD_WORDS;
    localparam int STORE_N = `STORE_WORDS;
    localparam int RUN_CYCLES = LOAD_N + STORE_N + 1;      // Start edge to done
    localparam int TIMEOUT_CYCLES = 4 * RUN_CYCLES + 100;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   comp_enb;
    logic                   busy;
    logic                   done;
    logic [`ADDR_WIDTH-1:0] mem_addr;
    logic                   mem_read_enb;
    logic [`MEM_WIDTH-1:0]  mem_data_in;
    logic [`ADDR_WIDTH-1:0] res_addr;
    logic [`MEM_WIDTH-1:0]  res_data_out;
    logic                   res_write_enb;

    logic [`MEM_WIDTH-1:0] mem [LOAD_N];   // Source tile, one row per two words
    logic [`MEM_WIDTH-1:0] expected;
    integer seed;
    int     data_errors = 0;
    int     ctrl_errors = 0;
    int     words_checked = 0;
    int     tiles_done = 0;
    int     cycle = 0;
    int     start_cycle = 0;
    int     done_cycle = -1000;
    int     last_gap = 0;
    int     load_cnt = 0;
    int     store_cnt = 0;
    logic   done_q = 1'b0;

    tile_convert_top DUT (
        .clk           (clk),
        .rst           (rst),
        .comp_enb      (comp_enb),
        .busy          (busy),
        .done          (done),
        .mem_addr      (mem_addr),
        .mem_read_enb  (mem_read_enb),
        .mem_data_in   (mem_data_in),
        .res_addr      (res_addr),
        .res_data_out  (res_data_out),
        .res_write_enb (res_write_enb)
    );

    always #2 clk = ~clk;

    assign mem_data_in = mem[mem_addr[4:0]];   // Data valid with the address

    // Sign, biased position of the leading one, remaining bits left-aligned
    function automatic logic [15:0] int8_to_bf16_ref(input logic signed [7:0] v);
        logic [7:0] mag;
        int         pos;
        int         rem;
        if (v == 0)
            return 16'h0000;
        if (v == -128)
            return 16'hC2FE;   // Saturates to -127.0
        mag = v[7] ? 8'(-v) : v;
        pos = 0;
        for (int i = 0; i < 8; i++) begin
            if (mag[i])
                pos = i;
        end
        rem = (int'(mag) - (1 << pos)) << (7 - pos);
        return {v[7], 8'(127 + pos), 7'(rem)};
    endfunction

    // Result word n holds tile elements 4n to 4n+3
    function automatic logic [`MEM_WIDTH-1:0] expected_word(input int n);
        logic [`MEM_WIDTH-1:0] word;
        int                    e;
        word = '0;
        for (int j = 0; j < 4; j++) begin
            e = 4 * n + j;
            word[j*16 +: 16] = int8_to_bf16_ref(mem[e / 8][(e % 8) * 8 +: 8]);
        end
        return word;
    endfunction

    task automatic check_ref_table;
        logic [7:0]  vals [8];
        logic [15:0] bf [8];
        vals = '{8'h00, 8'h01, 8'hFF, 8'h7F, 8'h80, 8'h40, 8'hFD, 8'h02};
        bf = '{16'h0000, 16'h3F80, 16'hBF80, 16'h42FE, 16'hC2FE, 16'h4280, 16'hC040, 16'h4000};
        for (int i = 0; i < 8; i++) begin
            assert (int8_to_bf16_ref(vals[i]) == bf[i]) else begin
                $display("ERROR %0t: reference maps %h to %h, expected %h",
                         $time, vals[i], int8_to_bf16_ref(vals[i]), bf[i]);
                data_errors++;
            end
        end
    endtask

    task automatic fill_directed;
        for (int i = 0; i < LOAD_N; i++)
            mem[i] = 64'h02FD_4080_7FFF_0100;   // 0, 1, -1, 127, -128, 64, -3, 2 from byte 0
    endtask

    task automatic fill_random;
        for (int i = 0; i < LOAD_N; i++)
            mem[i] = {$random(seed), $random(seed)};
    endtask

    task automatic pulse_start;
        @(negedge clk);
        comp_enb = 1'b1;
        @(negedge clk);
        comp_enb = 1'b0;
    endtask

    task automatic wait_done;
        @(negedge clk);
        while (!done)
            @(negedge clk);
    endtask

    // Comparing process, also tracks phase order, timing and the timeout
    always @(posedge clk) begin
        if (!rst) begin
            assert (busy == (mem_read_enb || res_write_enb)) else begin
                $display("ERROR %0t: busy %b with read %b, write %b",
                         $time, busy, mem_read_enb, res_write_enb);
                ctrl_errors++;
            end
            assert (!(done && done_q)) else begin
                $display("ERROR %0t: done high for more than one cycle", $time);
                ctrl_errors++;
            end
            if (!busy && !done && comp_enb) begin   // Start edge
                start_cycle = cycle;
                last_gap = cycle - done_cycle;
                load_cnt = 0;
                store_cnt = 0;
            end
            if (mem_read_enb) begin
                assert (mem_addr == 16'(load_cnt)) else begin
                    $display("ERROR %0t: mem_addr %0d, expected %0d", $time, mem_addr, load_cnt);
                    ctrl_errors++;
                end
                load_cnt++;
            end
            if (res_write_enb) begin
                expected = expected_word(store_cnt);
                assert (load_cnt == LOAD_N && res_addr == 16'(store_cnt)) else begin
                    $display("ERROR %0t: res_addr %0d after %0d reads, expected %0d",
                             $time, res_addr, load_cnt, store_cnt);
                    ctrl_errors++;
                end
                assert (res_data_out == expected) else begin
                    $display("ERROR %0t: word %0d is %h, expected %h",
                             $time, store_cnt, res_data_out, expected);
                    data_errors++;
                end
                words_checked++;
                store_cnt++;
            end
            if (done) begin
                assert (load_cnt == LOAD_N && store_cnt == STORE_N
                        && cycle - start_cycle == RUN_CYCLES) else begin
                    $display("ERROR %0t: done after %0d cycles, %0d reads, %0d writes",
                             $time, cycle - start_cycle, load_cnt, store_cnt);
                    ctrl_errors++;
                end
                done_cycle = cycle;
                tiles_done++;
            end
        end
        done_q = done;
        cycle++;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: tiles not finished after %0d cycles", cycle);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        comp_enb = 1'b0;
        seed = 33513;
        fill_directed();
        check_ref_table();
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!busy && !done && !mem_read_enb && !res_write_enb) else begin
            $display("Outputs were active in IDLE after reset");
            ctrl_errors++;
        end
        pulse_start();
        wait_done();
        fill_random();
        pulse_start();
        wait_done();
        // Two tiles with comp_enb held high
        fill_random();
        comp_enb = 1'b1;
        wait_done();
        fill_random();       // New data while in DONE
        repeat (2) @(negedge clk);
        comp_enb = 1'b0;
        wait_done();
        assert (last_gap == 1) else begin
            $display("Second tile started %0d cycles after done instead of one", last_gap);
            ctrl_errors++;
        end
        repeat (3) @(negedge clk);
        assert (tiles_done == 4 && words_checked == 4 * STORE_N) else begin
            $display("Not all tiles completed: %0d tiles, %0d words", tiles_done, words_checked);
            ctrl_errors++;
        end
        $display("Errors: %0d data, %0d control, %0d result words checked",
                 data_errors, ctrl_errors, words_checked);
        if (data_errors + ctrl_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: hw/tile_convert_top.sv
`timescale 1ns/100ps
`include "conv_cfg.svh"

module tile_convert_top
    import conv_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   comp_enb,
    output logic                   busy,
    output logic                   done,
    output logic [`ADDR_WIDTH-1:0] mem_addr,
    output logic                   mem_read_enb,
    input  logic [`MEM_WIDTH-1:0]  mem_data_in,
    output logic [`ADDR_WIDTH-1:0] res_addr,
    output logic [`MEM_WIDTH-1:0]  res_data_out,
    output logic                   res_write_enb
);

    line_t      line_data;
    logic [3:0] line_index;
    logic       line_write;

    tile_ctrl_if ctrl ();

    tile_ctrl_fsm u_fsm (
        .clk      (clk),
        .rst      (rst),
        .comp_enb (comp_enb),
        .busy     (busy),
        .done     (done),
        .ctrl     (ctrl.fsm)
    );

    tile_word_counter u_counter (
        .clk  (clk),
        .rst  (rst),
        .ctrl (ctrl.counter)
    );

    line_assembler u_assembler (
        .clk         (clk),
        .rst         (rst),
        .ctrl        (ctrl.datapath),
        .mem_data_in (mem_data_in),
        .line_data   (line_data),
        .line_index  (line_index),
        .line_write  (line_write)
    );

    tile_buffer u_buffer (
        .clk          (clk),
        .line_data    (line_data),
        .line_index   (line_index),
        .line_write   (line_write),
        .ctrl         (ctrl.datapath),
        .res_data_out (res_data_out)
    );

    // One counter serves both address buses
    assign mem_addr      = {{(`ADDR_WIDTH - `COUNT_WIDTH){1'b0}}, ctrl.word_count};
    assign res_addr      = {{(`ADDR_WIDTH - `COUNT_WIDTH){1'b0}}, ctrl.word_count};
    assign mem_read_enb  = ctrl.load_en;
    assign res_write_enb = ctrl.store_en;

endmodule

// File: hw/tile_ctrl_fsm.sv
`timescale 1ns/100ps

module tile_ctrl_fsm
    import conv_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     comp_enb,
    output logic     busy,
    output logic     done,
    tile_ctrl_if.fsm ctrl
);

    tile_state_e state;
    tile_state_e state_next;

    always_ff @(posedge clk) begin
        if (rst)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (comp_enb)
                    state_next = LOAD;
            end
            LOAD: begin
                if (ctrl.tile_last)
                    state_next = STORE;   // Straight into write-back
            end
            STORE: begin
                if (ctrl.tile_last)
                    state_next = DONE;
            end
            DONE: state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    assign ctrl.load_en  = (state == LOAD);
    assign ctrl.store_en = (state == STORE);

    assign busy = (state == LOAD) || (state == STORE);
    assign done = (state == DONE);   // One cycle pulse

    a_phase_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(ctrl.load_en && ctrl.store_en)
    );

endmodule

// File: hw/tile_word_counter.sv
`timescale 1ns/100ps
`include "conv_cfg.svh"

module tile_word_counter
    import conv_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    tile_ctrl_if.counter ctrl
);

    count_t count;
    logic   active;

    assign active = ctrl.load_en || ctrl.store_en;

    // Holds zero outside a phase and wraps to zero on the last word,
    // so each phase starts at word 0
    always_ff @(posedge clk) begin
        if (rst)
            count <= '0;
        else if (!active || ctrl.tile_last)
            count <= '0;
        else
            count <= count + 1'b1;
    end

    assign ctrl.word_count = count;

    assign ctrl.tile_last = (ctrl.load_en && count == count_t'(`LOAD_WORDS - 1)) ||
                            (ctrl.store_en && count == count_t'(`STORE_WORDS - 1));

    a_load_limit: assert property (
        @(posedge clk) disable iff (rst)
        ctrl.load_en |-> count < `LOAD_WORDS
    );

endmodule

// File: hw/tile_buffer.sv
`timescale 1ns/100ps
`include "conv_cfg.svh"

module tile_buffer
    import conv_pkg::*;
(
    input  logic                  clk,
    input  line_t                 line_data,
    input  logic [3:0]            line_index,
    input  logic                  line_write,
    tile_ctrl_if.datapath         ctrl,
    output logic [`MEM_WIDTH-1:0] res_data_out
);

    line_t      lines [`TILE_DIM];
    logic [3:0] rd_line;
    logic [1:0] rd_slice;

    always_ff @(posedge clk) begin
        if (line_write)
            lines[line_index] <= line_data;
    end

    // Four result words per line, lowest elements first
    assign rd_line  = 4'(ctrl.word_count / `WORDS_PER_LINE_OUT);
    assign rd_slice = 2'(ctrl.word_count % `WORDS_PER_LINE_OUT);

    assign res_data_out = lines[rd_line][rd_slice*`MEM_WIDTH +: `MEM_WIDTH];

endmodule

// File: hw/line_assembler.sv
`timescale 1ns/100ps
`include "conv_cfg.svh"

module line_assembler
    import conv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    tile_ctrl_if.datapath         ctrl,
    input  logic [`MEM_WIDTH-1:0] mem_data_in,
    output line_t                 line_data,
    output logic [3:0]            line_index,
    output logic                  line_write
);

    chunk_t chunk;       // Converted current word
    chunk_t low_chunk;   // First half of the line being built
    logic   odd_word;

    for (genvar i = 0; i < `INT8_PER_WORD; i++) begin : g_lane
        int8_to_bf16 u_conv (
            .value  (mem_data_in[i*8 +: 8]),
            .result (chunk[i*`BF16_WIDTH +: `BF16_WIDTH])
        );
    end

    assign odd_word = ctrl.word_count[0];

    always_ff @(posedge clk) begin
        if (ctrl.load_en && !odd_word)
            low_chunk <= chunk;
        if (ctrl.load_en && odd_word) begin
            line_data  <= {chunk, low_chunk};   // Lower word goes to the low half
            line_index <= 4'(ctrl.word_count / `CHUNKS_PER_LINE);
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            line_write <= 1'b0;
        else
            line_write <= ctrl.load_en && odd_word;
    end

    // A line write always trails a load cycle by one
    a_write_after_load: assert property (
        @(posedge clk) disable iff (rst)
        line_write |-> $past(ctrl.load_en)
    );

endmodule

// File: hw/int8_to_bf16.sv
`timescale 1ns/100ps

module int8_to_bf16
    import conv_pkg::*;
(
    input  int8_t value,
    output bf16_t result
);

    localparam logic [7:0] EXP_BIAS = 8'd127;
    localparam bf16_t      BF16_ZERO = 16'h0000;
    localparam bf16_t      BF16_NEG_127 = 16'hC2FE;   // Saturated -128

    logic [6:0] mag;
    logic [2:0] msb_pos;
    logic [7:0] aligned;

    // -128 wraps to zero here but is replaced below
    assign mag = value[7] ? (~value[6:0] + 7'd1) : value[6:0];

    always_comb begin
        msb_pos = 3'd0;
        for (int i = 0; i < 7; i++) begin
            if (mag[i])
                msb_pos = 3'(i);   // Highest set bit wins
        end
    end

    // Leading one moves to bit 7, bits below it form the fraction
    assign aligned = {1'b0, mag} << (3'd7 - msb_pos);

    always_comb begin
        if (value == 8'sh00)
            result = BF16_ZERO;
        else if (value == 8'sh80)
            result = BF16_NEG_127;
        else
            result = {value[7], EXP_BIAS + 8'(msb_pos), aligned[6:0]};
    end

endmodule

// File: hw/tile_ctrl_if.sv
`timescale 1ns/100ps
`include "conv_cfg.svh"

interface tile_ctrl_if;

    logic                    load_en;    // Memory read phase
    logic                    store_en;   // Result write phase
    logic [`COUNT_WIDTH-1:0] word_count;
    logic                    tile_last;  // Last word of the current phase

    modport fsm (
        output load_en,
        output store_en,
        input  tile_last
    );

    modport counter (
        input  load_en,
        input  store_en,
        output word_count,
        output tile_last
    );

    modport datapath (
        input load_en,
        input store_en,
        input word_count
    );

endinterface

// File: hw/conv_pkg.sv
`include "conv_cfg.svh"

package conv_pkg;

    typedef logic signed [7:0] int8_t;

    typedef logic [`BF16_WIDTH-1:0] bf16_t;

    // Eight converted values from one memory word
    typedef logic [`INT8_PER_WORD*`BF16_WIDTH-1:0] chunk_t;

    // One tile row in bfloat16
    typedef logic [`TILE_DIM*`BF16_WIDTH-1:0] line_t;

    typedef logic [`COUNT_WIDTH-1:0] count_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        STORE,
        DONE
    } tile_state_e;

endpackage

// File: hw/conv_cfg.svh
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// Tile geometry
`define TILE_DIM            16
`define MEM_WIDTH           64
`define BF16_WIDTH          16

`define INT8_PER_WORD       (`MEM_WIDTH / 8)

// Memory words that make up one 256-bit buffer line
`define CHUNKS_PER_LINE     ((`TILE_DIM * `BF16_WIDTH) / (`INT8_PER_WORD * `BF16_WIDTH))

`define LOAD_WORDS          ((`TILE_DIM * `TILE_DIM) / `INT8_PER_WORD)   // 32 reads
`define STORE_WORDS         ((`TILE_DIM * `TILE_DIM * `BF16_WIDTH) / `MEM_WIDTH) // 64 writes
`define WORDS_PER_LINE_OUT  ((`TILE_DIM * `BF16_WIDTH) / `MEM_WIDTH)

`define COUNT_WIDTH         6   // Wide enough for the store phase
`define ADDR_WIDTH          16

`endif
